//--- hdl/compare_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// compare datapath sizes
// word, lane and lane-count constants
// shared by the splitter, selector and top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package compare_pkg;

    // one operand word as seen on the input ports
    localparam int DATA_WIDTH = 32;

    // one packed lane, an 8-bit integer
    // read as signed or unsigned depending on the predicate
    localparam int LANE_WIDTH = 8;

    // lanes per word
    // the word must divide evenly into lanes
    localparam int LANE_COUNT = DATA_WIDTH / LANE_WIDTH;

    // lane i sits at bits i*LANE_WIDTH upward in every packed vector
    // so lane 0 is the least significant byte of the word
    // lane 3 is the most significant byte

    // the predicate vectors between lanes and selector are LANE_COUNT wide
    // bit i of each vector belongs to lane i
    // the output mask uses the same bit order

    // all lanes are compared in the same cycle
    // there is no lane width other than LANE_WIDTH

endpackage : compare_pkg

`default_nettype wire

//--- hdl/predicate_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// comparison predicate codes
// opcode width and the nine predicate
// selections understood by the selector
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package predicate_pkg;

    // width of the predicate code carried with each strobe
    localparam int OP_WIDTH = 4;

    // equality does not care about signedness
    localparam logic [OP_WIDTH-1:0] PRED_EQ    = 4'd0;

    // unsigned forms, lanes read as 0..255
    localparam logic [OP_WIDTH-1:0] PRED_LT_U  = 4'd1;
    localparam logic [OP_WIDTH-1:0] PRED_LTE_U = 4'd2;
    localparam logic [OP_WIDTH-1:0] PRED_GT_U  = 4'd3;
    localparam logic [OP_WIDTH-1:0] PRED_GTE_U = 4'd4;

    // signed forms, lanes read as -128..127
    localparam logic [OP_WIDTH-1:0] PRED_LT_S  = 4'd5;
    localparam logic [OP_WIDTH-1:0] PRED_LTE_S = 4'd6;
    localparam logic [OP_WIDTH-1:0] PRED_GT_S  = 4'd7;
    localparam logic [OP_WIDTH-1:0] PRED_GTE_S = 4'd8;

    // number of valid codes
    // anything at or above this is flagged as an opcode error
    localparam int PRED_COUNT = 9;

    // codes 9..15 return a zero mask with op_error set
    // there is no not-equal code
    // the caller inverts the PRED_EQ mask instead

endpackage : predicate_pkg

`default_nettype wire

//--- hdl/adder_subtractor_binary.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ripple adder/subtractor
// a+b or a-b with carry-out and signed
// overflow from the top two carries
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module adder_subtractor_binary #(
    parameter int WORD_WIDTH = 8
) (
    // 0 adds, 1 subtracts
    input  wire logic                  add_sub,
    // in subtract mode this acts as a borrow in
    input  wire logic                  carry_in,
    input  wire logic [WORD_WIDTH-1:0] a,
    input  wire logic [WORD_WIDTH-1:0] b,
    output logic      [WORD_WIDTH-1:0] sum,
    output logic                       carry_out,
    output logic                       overflow
);

    // b as seen by the adder, inverted when subtracting
    logic [WORD_WIDTH-1:0] b_eff;

    assign b_eff = add_sub ? ~b : b;

    always_comb begin
        // carry[i] is the carry into bit i
        logic [WORD_WIDTH:0] carry;

        // subtract is a + ~b + 1, so the carry in is forced high
        // a set carry_in then takes one back off, i.e. a borrow
        carry[0] = carry_in ^ add_sub;

        for (int i = 0; i < WORD_WIDTH; i++) begin
            sum[i]     = a[i] ^ b_eff[i] ^ carry[i];
            // generate, or propagate the incoming carry
            carry[i+1] = (a[i] & b_eff[i]) | (carry[i] & (a[i] ^ b_eff[i]));
        end

        // in subtract mode a clear carry-out means a borrow happened
        carry_out = carry[WORD_WIDTH];

        // signed overflow when the carry into the sign bit
        // disagrees with the carry out of it
        overflow  = carry[WORD_WIDTH] ^ carry[WORD_WIDTH-1];
    end

endmodule : adder_subtractor_binary

`default_nettype wire

//--- hdl/arithmetic_predicates_binary.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// arithmetic predicates of one word pair
// signed and unsigned compares derived
// from the flags of a - b
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module arithmetic_predicates_binary #(
    parameter int WORD_WIDTH = 8
) (
    input  wire logic [WORD_WIDTH-1:0] a,
    input  wire logic [WORD_WIDTH-1:0] b,

    output logic                       a_eq_b,

    output logic                       a_lt_b_unsigned,
    output logic                       a_lte_b_unsigned,
    output logic                       a_gt_b_unsigned,
    output logic                       a_gte_b_unsigned,

    output logic                       a_lt_b_signed,
    output logic                       a_lte_b_signed,
    output logic                       a_gt_b_signed,
    output logic                       a_gte_b_signed
);

    logic [WORD_WIDTH-1:0] difference;
    logic                  carry_out;
    logic                  overflow;

    // a - b, no borrow in
    adder_subtractor_binary #(
        .WORD_WIDTH (WORD_WIDTH)
    ) subtraction (
        .add_sub    (1'b1),
        .carry_in   (1'b0),
        .a          (a),
        .b          (b),
        .sum        (difference),
        .carry_out  (carry_out),
        .overflow   (overflow)
    );

    // sign of the raw difference, before any overflow correction
    logic negative;

    assign negative = difference[WORD_WIDTH-1];

    always_comb begin
        a_eq_b           = (difference == '0);

        // carry-out of a two's-complement subtract is an inverted borrow
        a_lt_b_unsigned  = ~carry_out;
        a_gte_b_unsigned = carry_out;
        a_lte_b_unsigned = a_lt_b_unsigned | a_eq_b;
        a_gt_b_unsigned  = a_gte_b_unsigned & ~a_eq_b;

        // the sign bit lies whenever the subtract overflowed
        a_lt_b_signed    = negative ^ overflow;
        a_gte_b_signed   = ~a_lt_b_signed;
        a_lte_b_signed   = a_lt_b_signed | a_eq_b;
        a_gt_b_signed    = a_gte_b_signed & ~a_eq_b;
    end

endmodule : arithmetic_predicates_binary

`default_nettype wire

//--- hdl/lane_splitter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// operand lane splitter
// captures a, b and op on the strobe and
// presents the words as packed lanes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module lane_splitter
    import compare_pkg::*;
    import predicate_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  valid_in,
    input  wire logic [DATA_WIDTH-1:0] a,
    input  wire logic [DATA_WIDTH-1:0] b,
    input  wire logic [OP_WIDTH-1:0]   op,
    output logic      [DATA_WIDTH-1:0] lane_a,
    output logic      [DATA_WIDTH-1:0] lane_b,
    output logic      [OP_WIDTH-1:0]   stage_op,
    output logic                       stage_valid
);

    // one register per lane and operand
    logic [LANE_WIDTH-1:0] a_lane_q [LANE_COUNT];
    logic [LANE_WIDTH-1:0] b_lane_q [LANE_COUNT];

    // strobe goes through the stage once, one cycle late
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= valid_in;
        end
    end

    // payload only loads on a strobe, otherwise it holds
    always_ff @(posedge clk) begin
        if (valid_in) begin
            stage_op <= op;
        end
    end

    for (genvar i = 0; i < LANE_COUNT; i++) begin : g_lane
        // cut lane i out of each word
        always_ff @(posedge clk) begin
            if (valid_in) begin
                a_lane_q[i] <= a[i*LANE_WIDTH +: LANE_WIDTH];
                b_lane_q[i] <= b[i*LANE_WIDTH +: LANE_WIDTH];
            end
        end

        // fixed layout for the comparators, lane i at i*LANE_WIDTH
        assign lane_a[i*LANE_WIDTH +: LANE_WIDTH] = a_lane_q[i];
        assign lane_b[i*LANE_WIDTH +: LANE_WIDTH] = b_lane_q[i];
    end

endmodule : lane_splitter

`default_nettype wire

//--- hdl/predicate_select.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// predicate selector
// picks the lane mask for the code,
// registers it with summaries and op_error
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module predicate_select
    import compare_pkg::*;
    import predicate_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  stage_valid,
    input  wire logic [OP_WIDTH-1:0]   stage_op,

    // bit i of each vector comes from lane i
    input  wire logic [LANE_COUNT-1:0] eq_lanes,
    input  wire logic [LANE_COUNT-1:0] lt_u_lanes,
    input  wire logic [LANE_COUNT-1:0] lte_u_lanes,
    input  wire logic [LANE_COUNT-1:0] gt_u_lanes,
    input  wire logic [LANE_COUNT-1:0] gte_u_lanes,
    input  wire logic [LANE_COUNT-1:0] lt_s_lanes,
    input  wire logic [LANE_COUNT-1:0] lte_s_lanes,
    input  wire logic [LANE_COUNT-1:0] gt_s_lanes,
    input  wire logic [LANE_COUNT-1:0] gte_s_lanes,

    output logic      [LANE_COUNT-1:0] mask,
    output logic                       any_true,
    output logic                       all_true,
    output logic                       op_error,
    output logic                       result_valid
);

    logic [LANE_COUNT-1:0] sel_mask;
    logic                  op_bad;

    // codes past the last predicate are rejected
    assign op_bad = (stage_op >= PRED_COUNT);

    always_comb begin
        case (stage_op)
            PRED_EQ:    sel_mask = eq_lanes;
            PRED_LT_U:  sel_mask = lt_u_lanes;
            PRED_LTE_U: sel_mask = lte_u_lanes;
            PRED_GT_U:  sel_mask = gt_u_lanes;
            PRED_GTE_U: sel_mask = gte_u_lanes;
            PRED_LT_S:  sel_mask = lt_s_lanes;
            PRED_LTE_S: sel_mask = lte_s_lanes;
            PRED_GT_S:  sel_mask = gt_s_lanes;
            PRED_GTE_S: sel_mask = gte_s_lanes;
            // bad code, nothing selected so both summaries read 0
            default:    sel_mask = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask         <= '0;
            any_true     <= 1'b0;
            all_true     <= 1'b0;
            op_error     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            // single-cycle strobe, no back-pressure
            result_valid <= stage_valid;
            // results hold between strobes
            if (stage_valid) begin
                mask     <= sel_mask;
                any_true <= |sel_mask;
                all_true <= &sel_mask;
                op_error <= op_bad;
            end
        end
    end

endmodule : predicate_select

`default_nettype wire

//--- hdl/simd_compare_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packed lane comparator, top level
// splitter, per-lane predicates, selector
// result two cycles after each strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module simd_compare_unit
    import compare_pkg::*;
    import predicate_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  valid_in,
    input  wire logic [DATA_WIDTH-1:0] a,
    input  wire logic [DATA_WIDTH-1:0] b,
    input  wire logic [OP_WIDTH-1:0]   op,
    output logic      [LANE_COUNT-1:0] mask,
    output logic                       any_true,
    output logic                       all_true,
    output logic                       op_error,
    output logic                       result_valid
);

    // splitter stage outputs
    logic [DATA_WIDTH-1:0] lane_a;
    logic [DATA_WIDTH-1:0] lane_b;
    logic [OP_WIDTH-1:0]   stage_op;
    logic                  stage_valid;

    // per-predicate lane vectors, bit i from lane i
    logic [LANE_COUNT-1:0] eq_lanes;
    logic [LANE_COUNT-1:0] lt_u_lanes;
    logic [LANE_COUNT-1:0] lte_u_lanes;
    logic [LANE_COUNT-1:0] gt_u_lanes;
    logic [LANE_COUNT-1:0] gte_u_lanes;
    logic [LANE_COUNT-1:0] lt_s_lanes;
    logic [LANE_COUNT-1:0] lte_s_lanes;
    logic [LANE_COUNT-1:0] gt_s_lanes;
    logic [LANE_COUNT-1:0] gte_s_lanes;

    // stage 1, capture and lane layout
    lane_splitter lane_splitter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_in    (valid_in),
        .a           (a),
        .b           (b),
        .op          (op),
        .lane_a      (lane_a),
        .lane_b      (lane_b),
        .stage_op    (stage_op),
        .stage_valid (stage_valid)
    );

    // all lanes compared at once, purely combinational
    for (genvar i = 0; i < LANE_COUNT; i++) begin : g_lane
        arithmetic_predicates_binary #(
            .WORD_WIDTH (LANE_WIDTH)
        ) lane_cmp_i (
            .a                (lane_a[i*LANE_WIDTH +: LANE_WIDTH]),
            .b                (lane_b[i*LANE_WIDTH +: LANE_WIDTH]),
            .a_eq_b           (eq_lanes[i]),
            .a_lt_b_unsigned  (lt_u_lanes[i]),
            .a_lte_b_unsigned (lte_u_lanes[i]),
            .a_gt_b_unsigned  (gt_u_lanes[i]),
            .a_gte_b_unsigned (gte_u_lanes[i]),
            .a_lt_b_signed    (lt_s_lanes[i]),
            .a_lte_b_signed   (lte_s_lanes[i]),
            .a_gt_b_signed    (gt_s_lanes[i]),
            .a_gte_b_signed   (gte_s_lanes[i])
        );
    end

    // stage 2, select and register the result
    predicate_select predicate_select_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .stage_valid  (stage_valid),
        .stage_op     (stage_op),
        .eq_lanes     (eq_lanes),
        .lt_u_lanes   (lt_u_lanes),
        .lte_u_lanes  (lte_u_lanes),
        .gt_u_lanes   (gt_u_lanes),
        .gte_u_lanes  (gte_u_lanes),
        .lt_s_lanes   (lt_s_lanes),
        .lte_s_lanes  (lte_s_lanes),
        .gt_s_lanes   (gt_s_lanes),
        .gte_s_lanes  (gte_s_lanes),
        .mask         (mask),
        .any_true     (any_true),
        .all_true     (all_true),
        .op_error     (op_error),
        .result_valid (result_valid)
    );

endmodule : simd_compare_unit

`default_nettype wire

//--- bench/simd_compare_unit_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the packed lane comparator
// directed table, seeded random phase and
// a lane model checked at each result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module simd_compare_unit_tb
    import compare_pkg::*;
    import predicate_pkg::*;
;

    localparam time CLK_PERIOD      = 8ns;
    localparam time DRIVE_DELAY     = 1ns;
    localparam int  RESET_CYCLES    = 5;
    localparam int  DIRECTED_COUNT  = 26;
    localparam int  RANDOM_COUNT    = 64;
    localparam int  TOTAL_COUNT     = DIRECTED_COUNT + RANDOM_COUNT;
    localparam logic [31:0] SEED    = 32'h83534721;
    // random entries may be preceded by one idle cycle each
    localparam int  CYCLE_LIMIT     = RESET_CYCLES + DIRECTED_COUNT + 2 * RANDOM_COUNT + 20;

    // expected response of one strobe
    typedef struct packed {
        logic [LANE_COUNT-1:0] mask;
        logic                  any_true;
        logic                  all_true;
        logic                  op_error;
    } result_t;

    logic                  clk;
    logic                  rst_n;
    logic                  valid_in;
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
    logic [OP_WIDTH-1:0]   op;
    logic [LANE_COUNT-1:0] mask;
    logic                  any_true;
    logic                  all_true;
    logic                  op_error;
    logic                  result_valid;

    // directed stimulus table
    string                 tbl_name [DIRECTED_COUNT];
    logic [DATA_WIDTH-1:0] tbl_a    [DIRECTED_COUNT];
    logic [DATA_WIDTH-1:0] tbl_b    [DIRECTED_COUNT];
    logic [OP_WIDTH-1:0]   tbl_op   [DIRECTED_COUNT];
    result_t               tbl_exp  [DIRECTED_COUNT];
    int                    tbl_size;

    // in-flight expectations, pushed per strobe and popped per result
    string                 name_queue [$];
    result_t               exp_queue  [$];

    // valid_in seen at the last two falling edges
    logic [1:0]            strobe_hist;
    int                    error_count;
    int                    test_count;
    int                    cycle_count;

    simd_compare_unit simd_compare_unit_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_in     (valid_in),
        .a            (a),
        .b            (b),
        .op           (op),
        .mask         (mask),
        .any_true     (any_true),
        .all_true     (all_true),
        .op_error     (op_error),
        .result_valid (result_valid)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    // lane model, slices compared as plain integers
    function automatic result_t model_result(input logic [DATA_WIDTH-1:0] wa,
                                             input logic [DATA_WIDTH-1:0] wb,
                                             input logic [OP_WIDTH-1:0]   code);
        result_t              r;
        logic [LANE_WIDTH-1:0] la;
        logic [LANE_WIDTH-1:0] lb;
        int                   ua;
        int                   ub;
        int                   sa;
        int                   sb;
        logic                 hit;
        r = '0;
        for (int i = 0; i < LANE_COUNT; i++) begin
            la = wa[i*LANE_WIDTH +: LANE_WIDTH];
            lb = wb[i*LANE_WIDTH +: LANE_WIDTH];
            ua = la;
            ub = lb;
            // sign extended to 32 bits
            sa = $signed(la);
            sb = $signed(lb);
            case (code)
                PRED_EQ:    hit = (ua == ub);
                PRED_LT_U:  hit = (ua < ub);
                PRED_LTE_U: hit = (ua <= ub);
                PRED_GT_U:  hit = (ua > ub);
                PRED_GTE_U: hit = (ua >= ub);
                PRED_LT_S:  hit = (sa < sb);
                PRED_LTE_S: hit = (sa <= sb);
                PRED_GT_S:  hit = (sa > sb);
                PRED_GTE_S: hit = (sa >= sb);
                default:    hit = 1'b0;
            endcase
            r.mask[i] = hit;
        end
        r.any_true = |r.mask;
        r.all_true = &r.mask;
        r.op_error = (code >= PRED_COUNT);
        return r;
    endfunction

    task automatic add_entry(input string name, input logic [31:0] wa, input logic [31:0] wb,
                             input logic [3:0] code, input logic [3:0] m,
                             input logic an, input logic al, input logic er);
        tbl_name[tbl_size]         = name;
        tbl_a[tbl_size]            = wa;
        tbl_b[tbl_size]            = wb;
        tbl_op[tbl_size]           = code;
        tbl_exp[tbl_size].mask     = m;
        tbl_exp[tbl_size].any_true = an;
        tbl_exp[tbl_size].all_true = al;
        tbl_exp[tbl_size].op_error = er;
        tbl_size++;
    endtask

    // expectations worked out by hand per lane, lane 0 is the low byte
    task automatic load_directed_table();
        tbl_size = 0;
        add_entry("eq_all", 32'h11223344, 32'h11223344, PRED_EQ, 4'b1111, 1, 1, 0);
        add_entry("eq_some", 32'h11223344, 32'h11AA33BB, PRED_EQ, 4'b1010, 1, 0, 0);
        add_entry("eq_none", 32'h00000000, 32'h01010101, PRED_EQ, 4'b0000, 0, 0, 0);
        // 7F/80, 80/7F, 01/FF, FF/01 from lane 0 up
        add_entry("top_lt_u", 32'hFF01807F, 32'h01FF7F80, PRED_LT_U, 4'b0101, 1, 0, 0);
        add_entry("top_gt_u", 32'hFF01807F, 32'h01FF7F80, PRED_GT_U, 4'b1010, 1, 0, 0);
        add_entry("top_lt_s", 32'hFF01807F, 32'h01FF7F80, PRED_LT_S, 4'b1010, 1, 0, 0);
        add_entry("top_gt_s", 32'hFF01807F, 32'h01FF7F80, PRED_GT_S, 4'b0101, 1, 0, 0);
        // lane 0 equal, lane 1 below, lane 2 80 vs 05, lane 3 above
        add_entry("mix_eq", 32'h60801042, 32'h20052042, PRED_EQ, 4'b0001, 1, 0, 0);
        add_entry("mix_lt_u", 32'h60801042, 32'h20052042, PRED_LT_U, 4'b0010, 1, 0, 0);
        add_entry("mix_lte_u", 32'h60801042, 32'h20052042, PRED_LTE_U, 4'b0011, 1, 0, 0);
        add_entry("mix_gt_u", 32'h60801042, 32'h20052042, PRED_GT_U, 4'b1100, 1, 0, 0);
        add_entry("mix_gte_u", 32'h60801042, 32'h20052042, PRED_GTE_U, 4'b1101, 1, 0, 0);
        add_entry("mix_lt_s", 32'h60801042, 32'h20052042, PRED_LT_S, 4'b0110, 1, 0, 0);
        add_entry("mix_lte_s", 32'h60801042, 32'h20052042, PRED_LTE_S, 4'b0111, 1, 0, 0);
        add_entry("mix_gt_s", 32'h60801042, 32'h20052042, PRED_GT_S, 4'b1000, 1, 0, 0);
        add_entry("mix_gte_s", 32'h60801042, 32'h20052042, PRED_GTE_S, 4'b1001, 1, 0, 0);
        add_entry("same_lte_s", 32'hDEADBEEF, 32'hDEADBEEF, PRED_LTE_S, 4'b1111, 1, 1, 0);
        add_entry("same_lt_u", 32'hDEADBEEF, 32'hDEADBEEF, PRED_LT_U, 4'b0000, 0, 0, 0);
        // equal words, so a leaked mask would show up
        for (int c = PRED_COUNT; c < 16; c++) begin
            add_entry($sformatf("bad_op_%0d", c), 32'h12345678, 32'h12345678, 4'(c),
                      4'b0000, 0, 0, 1);
        end
        // a good code clears op_error again
        add_entry("eq_after_bad", 32'hCAFEF00D, 32'hCAFEF00D, PRED_EQ, 4'b1111, 1, 1, 0);
    endtask

    // drive one strobe and queue what it should return
    task automatic apply_entry(input string name, input logic [DATA_WIDTH-1:0] wa,
                               input logic [DATA_WIDTH-1:0] wb, input logic [OP_WIDTH-1:0] code,
                               input result_t exp);
        valid_in = 1'b1;
        a        = wa;
        b        = wb;
        op       = code;
        name_queue.push_back(name);
        exp_queue.push_back(exp);
    endtask

    task automatic check_result();
        result_t exp;
        string   name;
        bit      ok;
        ok = 1'b1;
        if (exp_queue.size() == 0) begin
            $display("result_valid came back with no test outstanding");
            error_count++;
        end else begin
            exp  = exp_queue.pop_front();
            name = name_queue.pop_front();
            assert (mask == exp.mask) else begin
                $display("** Error: %s mask expected %b actual %b", name, exp.mask, mask);
                ok = 1'b0;
                error_count++;
            end
            assert (any_true == exp.any_true) else begin
                $display("** Error: %s any_true expected %b actual %b",
                         name, exp.any_true, any_true);
                ok = 1'b0;
                error_count++;
            end
            assert (all_true == exp.all_true) else begin
                $display("** Error: %s all_true expected %b actual %b",
                         name, exp.all_true, all_true);
                ok = 1'b0;
                error_count++;
            end
            assert (op_error == exp.op_error) else begin
                $display("** Error: %s op_error expected %b actual %b",
                         name, exp.op_error, op_error);
                ok = 1'b0;
                error_count++;
            end
            test_count++;
            $display("%s %s", ok ? "[ok] " : "[bad]", name);
        end
    endtask

    // outputs sampled mid cycle, well away from both edges
    always @(negedge clk) begin
        // idle while reset is low or not yet driven
        if (rst_n !== 1'b1) begin
            strobe_hist = 2'b00;
        end else begin
            if (strobe_hist[1]) begin
                assert (result_valid) else begin
                    $display("no result_valid two cycles after a strobe");
                    error_count++;
                    if (exp_queue.size() != 0) begin
                        $display("[bad] %s", name_queue.pop_front());
                        void'(exp_queue.pop_front());
                    end
                end
            end else begin
                assert (!result_valid) else begin
                    $display("result_valid high with no strobe two cycles earlier");
                    error_count++;
                end
            end
            if (result_valid) begin
                check_result();
            end
            strobe_hist = {strobe_hist[0], valid_in};
        end
    end

    // run limit from the worst-case test length
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d results outstanding",
                     cycle_count, exp_queue.size());
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        logic [DATA_WIDTH-1:0] ra;
        logic [DATA_WIDTH-1:0] rb;
        logic [OP_WIDTH-1:0]   rop;
        rst_n       = 1'b0;
        valid_in    = 1'b0;
        a           = '0;
        b           = '0;
        op          = '0;
        strobe_hist = 2'b00;
        error_count = 0;
        test_count  = 0;
        cycle_count = 0;
        void'($urandom(SEED));
        load_directed_table();

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        @(negedge clk);
        assert ({mask, any_true, all_true, op_error, result_valid} == '0) else begin
            $display("** Error: reset outputs expected 0 actual %b",
                     {mask, any_true, all_true, op_error, result_valid});
            error_count++;
        end

        // directed table, one strobe per cycle
        for (int i = 0; i < tbl_size; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            apply_entry(tbl_name[i], tbl_a[i], tbl_b[i], tbl_op[i], tbl_exp[i]);
        end

        // random phase with occasional idle cycles
        for (int k = 0; k < RANDOM_COUNT; k++) begin
            if ($urandom % 2 == 1) begin
                @(posedge clk);
                #DRIVE_DELAY;
                valid_in = 1'b0;
            end
            ra  = $urandom;
            rb  = $urandom;
            rop = 4'($urandom % 16);
            // about one lane in four made equal
            for (int i = 0; i < LANE_COUNT; i++) begin
                if ($urandom % 4 == 0) begin
                    rb[i*LANE_WIDTH +: LANE_WIDTH] = ra[i*LANE_WIDTH +: LANE_WIDTH];
                end
            end
            @(posedge clk);
            #DRIVE_DELAY;
            apply_entry($sformatf("rand_%0d", k), ra, rb, rop, model_result(ra, rb, rop));
        end

        @(posedge clk);
        #DRIVE_DELAY;
        valid_in = 1'b0;

        // drain, then a few idle cycles for stray strobes
        while (exp_queue.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);

        assert (test_count == TOTAL_COUNT) else begin
            $display("only %0d of %0d results were checked", test_count, TOTAL_COUNT);
            error_count++;
        end

        $display("tests checked %0d of %0d, errors %0d", test_count, TOTAL_COUNT, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : simd_compare_unit_tb

`default_nettype wire

//--- simd_compare_unit.f
hdl/compare_pkg.sv
hdl/predicate_pkg.sv
hdl/adder_subtractor_binary.sv
hdl/arithmetic_predicates_binary.sv
hdl/lane_splitter.sv
hdl/predicate_select.sv
hdl/simd_compare_unit.sv
bench/simd_compare_unit_tb.sv

//--- Makefile
# Verilator build, run, lint and clean for the packed lane comparator
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= simd_compare_unit_tb
RTL_TOP   ?= simd_compare_unit
FILELIST  ?= simd_compare_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall

# RTL sources only, taken from the file list
RTL_SRCS  := $(shell grep '^hdl/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, the exit status follows it
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "run did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
